//--- rtl/cluster_cfg_pkg.sv
// Size and latency constants shared by every block of the execution cluster
package cluster_cfg_pkg;

  // Cluster geometry
  localparam int unsigned NumUnits = 4;
  localparam int unsigned UnitIdxW = (NumUnits > 1) ? $clog2(NumUnits) : 1;

  // Datapath widths
  localparam int unsigned DataW = 32;
  localparam int unsigned TagW  = 4;

  // Cycles from acceptance to result valid
  localparam int unsigned LatAlu = 1;
  localparam int unsigned LatMul = 3;

  // Width of the per-unit latency down-counter
  localparam int unsigned LatW = $clog2(LatMul + 1);

endpackage

//--- rtl/cluster_types_pkg.sv
// Opcode, state and payload types passed between the cluster blocks; import where used
package cluster_types_pkg;

  import cluster_cfg_pkg::*;

  // Operations the units understand
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_MUL = 3'd4
  } fu_op_e;

  // Unit FSM, busy from start until its result is granted
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } unit_state_e;

  // Issued operation
  typedef struct packed {
    fu_op_e             op;
    logic [DataW-1:0]   opa;
    logic [DataW-1:0]   opb;
    logic [TagW-1:0]    tag;
  } fu_req_t;

  // Finished result, tag travels with the value
  typedef struct packed {
    logic [TagW-1:0]    tag;
    logic [DataW-1:0]   value;
  } fu_res_t;

  // Common data bus beat
  typedef struct packed {
    logic               valid;
    fu_res_t            res;
  } cdb_t;

endpackage

//--- rtl/prio_enc.sv
// Priority encoder over N request lines; INV set picks the lowest index, clear the highest
module prio_enc #(
  parameter int unsigned N   = 4,
  parameter bit          INV = 1'b1,
  localparam int unsigned IdxW = (N > 1) ? $clog2(N) : 1
) (
  input  logic [N-1:0]    lines_i,
  output logic [IdxW-1:0] enc_o,
  output logic            valid_o
);

  // Any line set at all
  assign valid_o = |lines_i;

  // Last match in scan order wins
  always_comb begin : scan
    enc_o = '0;
    if (INV) begin
      // Scan downwards so the lowest set line is kept
      for (int i = N - 1; i >= 0; i--) begin
        if (lines_i[i]) enc_o = IdxW'(i);
      end
    end else begin
      // Scan upwards so the highest set line is kept
      for (int i = 0; i < N; i++) begin
        if (lines_i[i]) enc_o = IdxW'(i);
      end
    end
  end

endmodule

//--- rtl/issue_dispatch.sv
// Issue stage of the cluster; steers each accepted request to the lowest idle unit
module issue_dispatch
  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_valid_i,
  input  fu_req_t             issue_req_i,
  input  logic [NumUnits-1:0] unit_busy_i,
  output logic                issue_ready_o,
  output logic [NumUnits-1:0] unit_start_o,
  output fu_req_t             unit_req_o
);

  logic [NumUnits-1:0] start_q;
  logic [NumUnits-1:0] idle;
  logic [UnitIdxW-1:0] idle_idx;
  logic                idle_any;

  // Units started last edge count as busy
  assign idle = ~unit_busy_i & ~start_q;

  // Lowest-numbered idle unit
  prio_enc #(
    .N  (NumUnits),
    .INV(1'b1)
  ) i_idle_enc (
    .lines_i(idle),
    .enc_o  (idle_idx),
    .valid_o(idle_any)
  );

  // Accept while any unit can take work
  assign issue_ready_o = idle_any;

  // One-hot start on a transfer
  always_comb begin : start_dec
    unit_start_o = '0;
    if (issue_valid_i && idle_any) begin
      unit_start_o[idle_idx] = 1'b1;
    end
  end

  // Request is shared, only the start bit selects
  assign unit_req_o = issue_req_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : start_reg
    if (!rst_ni) begin
      start_q <= '0;
    end else begin
      start_q <= unit_start_o;
    end
  end

endmodule

//--- rtl/exec_unit.sv
// One execution unit of the cluster; runs an operation and holds the result until granted
module exec_unit
  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  input  logic    start_i,
  input  fu_req_t req_i,
  input  logic    ready_i,
  output logic    busy_o,
  output logic    valid_o,
  output fu_res_t res_o
);

  unit_state_e      state_q;
  logic [LatW-1:0]  cnt_q;
  logic             valid_q;
  fu_res_t          res_q;
  logic [DataW-1:0] result_d;
  logic [LatW-1:0]  lat_d;
  logic             accept;

  // -------------------------------------------------------------------
  // Datapath
  // -------------------------------------------------------------------
  always_comb begin : alu
    case (req_i.op)
      OP_ADD:  result_d = req_i.opa + req_i.opb;
      OP_SUB:  result_d = req_i.opa - req_i.opb;
      OP_AND:  result_d = req_i.opa & req_i.opb;
      OP_XOR:  result_d = req_i.opa ^ req_i.opb;
      // Low half of the product
      OP_MUL:  result_d = req_i.opa * req_i.opb;
      default: result_d = '0;
    endcase
  end

  // Latency by opcode
  assign lat_d  = (req_i.op == OP_MUL) ? LatW'(LatMul) : LatW'(LatAlu);
  assign accept = (state_q == ST_IDLE) && start_i;

  always_ff @(posedge clk_i) begin : res_reg
    if (accept) begin
      res_q <= '{tag: req_i.tag, value: result_d};
    end
  end

  // -------------------------------------------------------------------
  // Control FSM
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_reg
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Drop work and any held result
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_BUSY;
            cnt_q   <= lat_d;
          end
        end
        ST_BUSY: begin
          if (valid_q) begin
            // Held until the arbiter grants
            if (ready_i) begin
              valid_q <= 1'b0;
              state_q <= ST_IDLE;
            end
          end else if (cnt_q == LatW'(1)) begin
            valid_q <= 1'b1;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q - LatW'(1);
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign busy_o  = (state_q == ST_BUSY);
  assign valid_o = valid_q;
  assign res_o   = res_q;

endmodule

//--- rtl/rr_arbiter.sv
// Round-robin arbiter draining the unit results; unserved requesters are kept and served first
module rr_arbiter
  import cluster_cfg_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,

  // Unit side
  input  logic [NumUnits-1:0] valid_i,
  output logic [NumUnits-1:0] ready_o,

  // Reorder buffer side
  input  logic                ready_i,
  output logic                valid_o,

  // Select for the bus stage
  output logic [UnitIdxW-1:0] served_o
);

  // Requesters seen but not yet picked
  logic [NumUnits-1:0] rem_valid_q;
  logic [NumUnits-1:0] rem_valid_d;

  // Set under arbitration this cycle
  logic [NumUnits-1:0] pick_set;

  // Encoder result and its one-hot form
  logic [UnitIdxW-1:0] pick_idx;
  logic                pick_any;
  logic [NumUnits-1:0] pick_onehot;

  // -------------------------------------------------------------------
  // Set selection
  // -------------------------------------------------------------------
  // New valids only sampled once the remainder is empty
  assign pick_set = (|rem_valid_q) ? rem_valid_q : valid_i;

  // Lowest index wins within the set
  prio_enc #(
    .N  (NumUnits),
    .INV(1'b1)
  ) i_pick_enc (
    .lines_i(pick_set),
    .enc_o  (pick_idx),
    .valid_o(pick_any)
  );

  always_comb begin : pick_dec
    pick_onehot = '0;
    if (pick_any) begin
      pick_onehot[pick_idx] = 1'b1;
    end
  end

  // Picked unit leaves the set
  assign rem_valid_d = pick_set & ~pick_onehot;

  // -------------------------------------------------------------------
  // Outputs
  // -------------------------------------------------------------------
  assign valid_o  = pick_any;
  assign served_o = pick_idx;

  // Ready only with the reorder buffer ready
  always_comb begin : ready_gate
    if (ready_i) begin
      ready_o = pick_onehot;
    end else begin
      ready_o = '0;
    end
  end

  // Remainder advances every edge, back-pressure or not
  always_ff @(posedge clk_i or negedge rst_ni) begin : rem_reg
    if (!rst_ni) begin
      rem_valid_q <= '0;
    end else if (flush_i) begin
      rem_valid_q <= '0;
    end else begin
      rem_valid_q <= rem_valid_d;
    end
  end

endmodule

//--- rtl/cdb_mux.sv
// Common data bus stage; registers the granted unit result for broadcast to the reorder buffer
module cdb_mux
  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  fu_res_t             res_i [NumUnits],
  input  logic                grant_valid_i,
  input  logic [UnitIdxW-1:0] served_i,
  input  logic                rob_ready_i,
  output cdb_t                cdb_o
);

  logic    valid_q;
  fu_res_t res_q;

  // Broadcast valid, one cycle per grant
  always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= grant_valid_i && rob_ready_i;
    end
  end

  // Payload of the served unit
  always_ff @(posedge clk_i) begin : res_reg
    res_q <= res_i[served_i];
  end

  assign cdb_o = '{valid: valid_q, res: res_q};

endmodule

//--- rtl/exec_cluster_top.sv
// Top of the execution cluster; wires dispatch, the unit array, the arbiter and the bus stage
module exec_cluster_top
  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    flush_i,
  input  logic    issue_valid_i,
  input  fu_req_t issue_req_i,
  input  logic    rob_ready_i,
  output logic    issue_ready_o,
  output cdb_t    cdb_o
);

  // Dispatch to units
  logic [NumUnits-1:0] unit_start;
  fu_req_t             unit_req;
  logic [NumUnits-1:0] unit_busy;

  // Units to arbiter and bus stage
  logic [NumUnits-1:0] unit_valid;
  logic [NumUnits-1:0] unit_ready;
  fu_res_t             unit_res [NumUnits];

  // Arbiter to bus stage
  logic                grant_valid;
  logic [UnitIdxW-1:0] served;

  issue_dispatch i_dispatch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_valid_i(issue_valid_i),
    .issue_req_i  (issue_req_i),
    .unit_busy_i  (unit_busy),
    .issue_ready_o(issue_ready_o),
    .unit_start_o (unit_start),
    .unit_req_o   (unit_req)
  );

  // -------------------------------------------------------------------
  // Unit array
  // -------------------------------------------------------------------
  for (genvar u = 0; u < NumUnits; u++) begin : gen_units
    exec_unit i_unit (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .flush_i(flush_i),
      .start_i(unit_start[u]),
      .req_i  (unit_req),
      .ready_i(unit_ready[u]),
      .busy_o (unit_busy[u]),
      .valid_o(unit_valid[u]),
      .res_o  (unit_res[u])
    );
  end

  rr_arbiter i_arbiter (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush_i),
    .valid_i (unit_valid),
    .ready_o (unit_ready),
    .ready_i (rob_ready_i),
    .valid_o (grant_valid),
    .served_o(served)
  );

  cdb_mux i_cdb (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .res_i        (unit_res),
    .grant_valid_i(grant_valid),
    .served_i     (served),
    .rob_ready_i  (rob_ready_i),
    .cdb_o        (cdb_o)
  );

endmodule

//--- tests/exec_cluster_props.sv
// Arbiter assertions for the cluster testbench; bound into every rr_arbiter instance
module exec_cluster_props
  import cluster_cfg_pkg::*;
(
  input logic                clk_i,
  input logic                rst_ni,
  input logic [NumUnits-1:0] unit_valid_i,
  input logic [NumUnits-1:0] unit_ready_i,
  input logic                rob_ready_i
);

  // Failed assertion count
  int unsigned fail_cnt = 0;

  // At most one unit drained per cycle
  a_ready_onehot : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(unit_ready_i))
  else begin
    $error("Ready vector to the units has more than one bit set");
    fail_cnt++;
  end

  // Only units holding a result get a ready
  a_ready_needs_valid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (unit_ready_i & ~unit_valid_i) == '0)
  else begin
    $error("Ready given to a unit whose valid is low");
    fail_cnt++;
  end

  // Back-pressure from the reorder buffer
  a_no_ready_when_stalled : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rob_ready_i |-> (unit_ready_i == '0))
  else begin
    $error("Ready given while the reorder buffer is not ready");
    fail_cnt++;
  end

endmodule

//--- tests/exec_cluster_checker.sv
// Scoreboard of the cluster testbench; stores expected results at issue and checks each bus beat
module exec_cluster_checker
  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             issue_valid_i,
  input  logic             issue_ready_i,
  input  fu_req_t          issue_req_i,
  input  logic [DataW-1:0] exp_value_i,
  input  logic             rob_ready_i,
  input  logic             lat_check_i,
  input  cdb_t             cdb_i,
  output int unsigned      err_cnt_o,
  output int unsigned      pending_o,
  output int unsigned      bcast_cnt_o
);

  // Per-tag expectation indexed by tag
  fu_res_t               exp_res   [2**TagW];
  int unsigned           issue_cyc [2**TagW];
  int unsigned           exp_lat   [2**TagW];
  logic [2**TagW-1:0]    in_flight = '0;

  // Edge counter and last-edge copies of the inputs
  int unsigned cyc       = 0;
  logic        rst_q     = 1'b0;
  logic        rob_q     = 1'b0;
  logic        flush_q   = 1'b0;
  int unsigned mon_err   = 0;
  int unsigned task_err  = 0;
  int unsigned bcast_cnt = 0;

  assign err_cnt_o   = mon_err + task_err;
  assign pending_o   = $countones(in_flight);
  assign bcast_cnt_o = bcast_cnt;

  // Count comparison on request of the stimulus
  task automatic expect_count(input string name, input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, got);
      task_err++;
    end
  endtask

  // -------------------------------------------------------------------
  // Bus monitor
  // -------------------------------------------------------------------
  always @(posedge clk_i) begin : watch
    int unsigned     n;
    logic [TagW-1:0] t;
    logic [TagW-1:0] it;
    n  = 0;
    t  = cdb_i.res.tag;
    it = issue_req_i.tag;
    cyc     <= cyc + 1;
    rst_q   <= rst_ni;
    rob_q   <= rob_ready_i;
    flush_q <= flush_i;
    if (rst_ni) begin
      // First edge out of reset
      if (!rst_q && cdb_i.valid) begin
        $display("Fail at %0t: cdb_o.valid after reset expected 0 got 1", $time);
        n++;
      end
      if (!rst_q && !issue_ready_i) begin
        $display("Fail at %0t: issue_ready_o after reset expected 1 got 0", $time);
        n++;
      end
      if (flush_q && !issue_ready_i) begin
        $display("Fail at %0t: issue_ready_o after flush expected 1 got 0", $time);
        n++;
      end
      if (cdb_i.valid) begin
        bcast_cnt <= bcast_cnt + 1;
        if (!rob_q) begin
          $display("Fail at %0t: cdb_o.valid after rob_ready_i low expected 0 got 1",
                   $time);
          n++;
        end
        if (!in_flight[t]) begin
          $display("Broadcast of tag %0d at %0t that is not in flight", t, $time);
          n++;
        end else begin
          if (cdb_i.res.value !== exp_res[t].value) begin
            $display("Fail at %0t: cdb_o.res.value (tag %0d) expected %h got %h",
                     $time, t, exp_res[t].value, cdb_i.res.value);
            n++;
          end
          // Broadcast edge is one before this sampling edge
          if (lat_check_i && (cyc - issue_cyc[t] - 1 != exp_lat[t])) begin
            $display("Fail at %0t: cdb_o latency (tag %0d) expected %0d got %0d",
                     $time, t, exp_lat[t], cyc - issue_cyc[t] - 1);
            n++;
          end
          in_flight[t] <= 1'b0;
        end
      end
      // Lost results
      for (int i = 0; i < 2**TagW; i++) begin
        if (in_flight[i] && (cyc - issue_cyc[i] > 400)) begin
          $display("Tag %0d was not broadcast within 400 cycles, time %0t", i, $time);
          n++;
          in_flight[i] <= 1'b0;
        end
      end
      // New transfer on the issue port
      if (issue_valid_i && issue_ready_i && !flush_i) begin
        if (in_flight[it]) begin
          $display("Tag %0d issued again while still in flight, time %0t", it, $time);
          n++;
        end
        in_flight[it] <= 1'b1;
        exp_res[it]   <= '{tag: it, value: exp_value_i};
        issue_cyc[it] <= cyc;
        exp_lat[it]   <= ((issue_req_i.op == OP_MUL) ? LatMul : LatAlu) + 1;
      end
      // In-flight work is discarded
      if (flush_i) begin
        in_flight <= '0;
      end
    end
    mon_err <= mon_err + n;
  end

endmodule

//--- tests/tb_exec_cluster.sv
// Top testbench of the execution cluster; drives issue traffic, back-pressure and flush
module tb_exec_cluster
  import cluster_cfg_pkg::*;
  import cluster_types_pkg::*;
();

  logic               clk;
  logic               rst_n;
  logic               flush;
  logic               issue_valid;
  fu_req_t            issue_req;
  logic               rob_ready;
  logic               issue_ready;
  cdb_t               cdb;
  logic [DataW-1:0]   exp_value;
  logic               lat_check;
  int unsigned        err_cnt;
  int unsigned        pending;
  int unsigned        bcast_cnt;
  logic [TagW-1:0]    next_tag;
  logic [2**TagW-1:0] tag_busy;
  int unsigned        bp_mode;
  int unsigned        tests_run;

  // Expected value from opcode and operands
  function automatic logic [DataW-1:0] ref_value(input fu_req_t req);
    logic [2*DataW-1:0] prod;
    prod = req.opa * req.opb;
    case (req.op)
      OP_ADD:  return req.opa + req.opb;
      OP_SUB:  return req.opa - req.opb;
      OP_AND:  return req.opa & req.opb;
      OP_XOR:  return req.opa ^ req.opb;
      OP_MUL:  return prod[DataW-1:0];
      default: return '0;
    endcase
  endfunction

  function automatic fu_req_t rand_req();
    fu_req_t req;
    req.op  = fu_op_e'($urandom_range(0, 4));
    req.opa = $urandom;
    req.opb = $urandom;
    req.tag = '0;
    return req;
  endfunction

  initial clk = 1'b0;
  always #2 clk = ~clk;

  assign exp_value = ref_value(issue_req);

  exec_cluster_top i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .flush_i      (flush),
    .issue_valid_i(issue_valid),
    .issue_req_i  (issue_req),
    .rob_ready_i  (rob_ready),
    .issue_ready_o(issue_ready),
    .cdb_o        (cdb)
  );

  exec_cluster_checker i_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .flush_i      (flush),
    .issue_valid_i(issue_valid),
    .issue_ready_i(issue_ready),
    .issue_req_i  (issue_req),
    .exp_value_i  (exp_value),
    .rob_ready_i  (rob_ready),
    .lat_check_i  (lat_check),
    .cdb_i        (cdb),
    .err_cnt_o    (err_cnt),
    .pending_o    (pending),
    .bcast_cnt_o  (bcast_cnt)
  );

  bind rr_arbiter exec_cluster_props i_props (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .unit_valid_i(valid_i),
    .unit_ready_i(ready_o),
    .rob_ready_i (ready_i)
  );

  // ROB ready low in phase 0 and high in phase 1 with random gaps otherwise
  always @(posedge clk) begin
    case (bp_mode)
      0:       rob_ready <= 1'b0;
      1:       rob_ready <= 1'b1;
      default: rob_ready <= ($urandom_range(0, 2) != 0);
    endcase
  end

  // Tags in flight until their broadcast
  always @(posedge clk) begin
    if (flush) begin
      tag_busy <= '0;
    end else begin
      if (cdb.valid) tag_busy[cdb.res.tag] <= 1'b0;
      if (issue_valid && issue_ready) tag_busy[issue_req.tag] <= 1'b1;
    end
  end

  // -------------------------------------------------------------------
  // Run control
  // -------------------------------------------------------------------
  task automatic finish_run(input bit timed_out);
    int unsigned total;
    total = err_cnt + i_dut.i_arbiter.i_props.fail_cnt;
    $display("Tests run %0d, broadcasts %0d, errors %0d", tests_run, bcast_cnt, total);
    if (total == 0 && !timed_out) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  task automatic give_up(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    finish_run(1'b1);
  endtask

  task automatic end_test(input string name, input int unsigned err_mark);
    tests_run++;
    $display("Test %s finished with %0d new errors", name, err_cnt - err_mark);
  endtask

  // One issue transfer that returns on the accepting edge
  task automatic send(input fu_req_t req);
    int unsigned n;
    n = 0;
    while (tag_busy[next_tag]) begin
      @(posedge clk);
      n++;
      if (n > 1000) give_up("a free tag");
    end
    req.tag = next_tag;
    issue_valid <= 1'b1;
    issue_req   <= req;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 1000) give_up("issue_ready_o");
    end while (!issue_ready);
    issue_valid <= 1'b0;
    next_tag = next_tag + 1'b1;
  endtask

  task automatic drain();
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 1000) give_up("outstanding broadcasts");
    end while (pending != 0);
  endtask

  initial begin : main
    fu_req_t     req;
    int unsigned accepted;
    int unsigned err_mark;
    void'($urandom(32'hdd7e));
    rst_n       = 1'b0;
    flush       = 1'b0;
    issue_valid = 1'b0;
    issue_req   = '0;
    rob_ready   = 1'b0;
    lat_check   = 1'b0;
    bp_mode     = 0;
    tag_busy    = '0;
    next_tag    = '0;
    tests_run   = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Idle outputs after reset
    err_mark = err_cnt;
    @(posedge clk);
    @(posedge clk);
    end_test("reset", err_mark);

    // One operation per opcode, exact latency
    err_mark = err_cnt;
    bp_mode   <= 1;
    lat_check <= 1'b1;
    for (int i = 0; i < 5; i++) begin
      req    = rand_req();
      req.op = fu_op_e'(i);
      send(req);
      drain();
    end
    lat_check <= 1'b0;
    end_test("single ops", err_mark);

    // Fill every unit with the bus stalled
    err_mark = err_cnt;
    bp_mode <= 0;
    @(posedge clk);
    accepted = 0;
    req      = rand_req();
    req.tag  = next_tag;
    issue_valid <= 1'b1;
    issue_req   <= req;
    do begin
      @(posedge clk);
      if (issue_ready) begin
        accepted++;
        next_tag = next_tag + 1'b1;
        req      = rand_req();
        req.tag  = next_tag;
        issue_req <= req;
      end
    end while (issue_ready && accepted <= NumUnits);
    issue_valid <= 1'b0;
    i_checker.expect_count("issue_ready_o transfers before stall", accepted, NumUnits);
    bp_mode <= 1;
    drain();
    end_test("full load", err_mark);

    // Random traffic under random back-pressure
    err_mark = err_cnt;
    bp_mode <= 2;
    for (int i = 0; i < 300; i++) begin
      send(rand_req());
      if ($urandom_range(0, 3) == 0) @(posedge clk);
    end
    bp_mode <= 1;
    drain();
    end_test("random traffic", err_mark);

    // Flush with every unit holding a result and then resume
    err_mark = err_cnt;
    bp_mode <= 0;
    for (int i = 0; i < NumUnits; i++) begin
      send(rand_req());
    end
    // Bus opens at the flush edge so stale results would reach it
    bp_mode <= 1;
    flush   <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
    end
    for (int i = 0; i < 6; i++) begin
      send(rand_req());
    end
    drain();
    end_test("flush", err_mark);

    finish_run(1'b0);
  end

endmodule

//--- files.f
rtl/cluster_cfg_pkg.sv
rtl/cluster_types_pkg.sv
rtl/prio_enc.sv
rtl/issue_dispatch.sv
rtl/exec_unit.sv
rtl/rr_arbiter.sv
rtl/cdb_mux.sv
rtl/exec_cluster_top.sv
tests/exec_cluster_props.sv
tests/exec_cluster_checker.sv
tests/tb_exec_cluster.sv
